/* testbench/vrf_cases.txt */
// Four lanes of: op index strobe data, then read addr 0..3, mode, expected port 0 low word
// Data d fills {~d,d,~d,d}; mode 0 model, 1 word check, 2 random lanes, 3 early read
1 01 0000 11111111 1 02 0000 22222222 1 03 0000 33333333 1 04 0000 44444444 01 02 03 04 1 11111111
2 01 0003 aabbccdd 0 02 ffff ffffffff 0 00 0000 00000000 0 00 0000 00000000 01 02 00 00 1 1111ccdd
1 05 0000 01010101 2 05 000f 02020202 2 05 0001 03030303 0 00 0000 00000000 05 01 02 03 1 02020203
2 06 000c aa55aa55 1 07 0000 77777777 1 08 0000 88888888 2 06 0003 12345678 06 07 08 05 1 aa555678
0 00 0000 00000000 0 00 0000 00000000 1 00 0000 c0ffee00 0 00 0000 00000000 00 01 02 03 3 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 00 06 07 08 1 c0ffee00
2 00 0001 000000ab 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 00 05 06 01 1 c0ffeeab
0 00 0000 00000000 1 01 0000 99999999 0 00 0000 00000000 0 00 0000 00000000 01 00 02 03 3 1111ccdd
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 01 02 03 04 1 99999999
2 09 0001 11111111 2 09 0002 22222222 2 09 0004 33333333 2 09 0008 44444444 09 00 01 05 1 44332211
1 09 0000 aaaaaaaa 1 09 0000 bbbbbbbb 1 09 0000 cccccccc 1 09 0000 dddddddd 09 08 07 06 1 dddddddd
1 1f 0000 0badf00d 1 1e 0000 deadbeef 2 10 00f0 5a5a5a5a 2 1f ff00 13579bdf 1f 1e 10 00 0 00000000
2 0a ffff 01234567 2 0b 8001 89abcdef 1 0a 0000 fedcba98 2 0b 7ffe 76543210 0a 0b 1f 10 0 00000000
2 02 f000 12345678 0 00 0000 00000000 0 00 0000 00000000 0 02 ffff 00000000 02 03 04 00 1 22222222
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 00 01 02 03 2 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 04 05 06 07 2 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 07 03 00 05 2 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 01 06 02 04 2 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 03 03 07 00 2 00000000
0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 0 00 0000 00000000 05 02 06 01 2 00000000

/* flist.f */
+incdir+verilog
verilog/rvv_vrf_pkg.sv
verilog/rvv_wb_pkg.sv
verilog/rvv_backend_if.sv
verilog/rvv_backend_vrf_reg.sv
verilog/rvv_backend_retire.sv
verilog/rvv_backend_vrf.sv
verilog/rvv_backend_dispatch_read.sv
verilog/rvv_backend_vrf_top.sv
testbench/tb_rvv_vrf.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the VRF testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rvv_vrf -Mdir obj_dir -f flist.f \
  && ./obj_dir/Vtb_rvv_vrf | tee /dev/stderr | grep -qx "Test OK" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

/* testbench/tb_rvv_vrf.sv */
// Testbench for the vector register file subsystem with a byte-level reference model
`timescale 1ns/1ps
`include "rvv_config.svh"

module tb_rvv_vrf;

  localparam int NUM_CASES       = 20;
  localparam int CASE_WORDS      = 22;
  localparam int RESET_CYCLES    = 10;
  localparam int CYCLES_PER_CASE = 8;
  localparam int WATCHDOG_CYCLES = NUM_CASES * CYCLES_PER_CASE + RESET_CYCLES;

  logic                clk;
  logic                rst_n;
  rvv_wb_pkg::wb_op_e  wb_op     [`WB_PORTS];
  rvv_vrf_pkg::vidx_t  wb_index  [`WB_PORTS];
  rvv_vrf_pkg::vreg_t  wb_data   [`WB_PORTS];
  rvv_vrf_pkg::vstrb_t wb_strobe [`WB_PORTS];
  logic                rd_req;
  rvv_vrf_pkg::vidx_t  rd_addr   [`RD_PORTS];
  logic                rd_valid;
  rvv_vrf_pkg::vreg_t  rd_data   [`RD_PORTS];
  rvv_vrf_pkg::vreg_t  v0_data;

  logic [31:0]         case_mem  [NUM_CASES*CASE_WORDS];
  rvv_vrf_pkg::vreg_t  model     [`VREG_NUM];
  logic [1:0]          lane_op   [`WB_PORTS];
  rvv_vrf_pkg::vidx_t  lane_idx  [`WB_PORTS];
  rvv_vrf_pkg::vstrb_t lane_strb [`WB_PORTS];
  rvv_vrf_pkg::vreg_t  lane_data [`WB_PORTS];
  rvv_vrf_pkg::vidx_t  raddr     [`RD_PORTS];
  rvv_vrf_pkg::vreg_t  exp_rd    [`RD_PORTS];
  rvv_vrf_pkg::vreg_t  exp_v0;
  integer              seed;
  int                  errors;
  int                  failed_tests;

  rvv_backend_vrf_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_op     (wb_op),
    .wb_index  (wb_index),
    .wb_data   (wb_data),
    .wb_strobe (wb_strobe),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .v0_data   (v0_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Eight cycles per case plus reset
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // File data word d fills a register as {~d, d, ~d, d}
  function automatic rvv_vrf_pkg::vreg_t expand_word(input logic [31:0] d);
    return {~d, d, ~d, d};
  endfunction

  task automatic load_case(input int k, output int mode, output logic [31:0] exp_word);
    int          base;
    logic [31:0] rnd;
    logic [31:0] opnum;
    base     = k * CASE_WORDS;
    mode     = int'(case_mem[base+20]);
    exp_word = case_mem[base+21];
    for (int l = 0; l < `WB_PORTS; l++) begin
      if (mode == 2) begin
        rnd          = $random(seed);
        opnum        = rnd % 32'd3;
        lane_op[l]   = opnum[1:0];
        rnd          = $random(seed);
        lane_idx[l]  = {2'b00, rnd[2:0]};
        rnd          = $random(seed);
        lane_strb[l] = rnd[15:0];
        lane_data[l] = {$random(seed), $random(seed), $random(seed), $random(seed)};
      end else begin
        lane_op[l]   = case_mem[base+4*l][1:0];
        lane_idx[l]  = case_mem[base+4*l+1][4:0];
        lane_strb[l] = case_mem[base+4*l+2][15:0];
        lane_data[l] = expand_word(case_mem[base+4*l+3]);
      end
    end
    for (int p = 0; p < `RD_PORTS; p++) begin
      raddr[p] = case_mem[base+16+p][4:0];
    end
  endtask

  // Lanes in ascending order, so a later lane's byte overwrites an earlier one
  task automatic apply_model();
    for (int l = 0; l < `WB_PORTS; l++) begin
      for (int b = 0; b < `VLENB; b++) begin
        if ((lane_op[l] == rvv_wb_pkg::WB_FULL) ||
            ((lane_op[l] == rvv_wb_pkg::WB_MASKED) && lane_strb[l][b])) begin
          model[lane_idx[l]][b*8 +: 8] = lane_data[l][b*8 +: 8];
        end
      end
    end
  endtask

  task automatic capture_expected();
    for (int p = 0; p < `RD_PORTS; p++) begin
      exp_rd[p] = model[raddr[p]];
    end
    exp_v0 = model[0];
  endtask

  task automatic drive_lanes();
    for (int l = 0; l < `WB_PORTS; l++) begin
      wb_op[l]     <= rvv_wb_pkg::wb_op_e'(lane_op[l]);
      wb_index[l]  <= lane_idx[l];
      wb_strobe[l] <= lane_strb[l];
      wb_data[l]   <= lane_data[l];
    end
  endtask

  task automatic drive_no_write();
    for (int l = 0; l < `WB_PORTS; l++) begin
      wb_op[l] <= rvv_wb_pkg::WB_NONE;
    end
  endtask

  task automatic issue_read();
    rd_req <= 1'b1;
    for (int p = 0; p < `RD_PORTS; p++) begin
      rd_addr[p] <= raddr[p];
    end
  endtask

  task automatic collect_read(input string name, input bit check_word,
                              input logic [31:0] exp_word);
    int waited;
    waited = 0;
    @(negedge clk);
    while ((rd_valid !== 1'b1) && (waited < 4)) begin
      @(negedge clk);
      waited++;
    end
    assert (rd_valid === 1'b1) else begin
      $display("%s: rd_valid never rose after the read request", name);
      errors++;
    end
    if (rd_valid === 1'b1) begin
      for (int p = 0; p < `RD_PORTS; p++) begin
        assert (rd_data[p] === exp_rd[p]) else begin
          $display("FAIL %0t: %s port %0d reg %0d read %h, expected %h",
                   $time, name, p, raddr[p], rd_data[p], exp_rd[p]);
          errors++;
        end
      end
      assert (v0_data === exp_v0) else begin
        $display("FAIL %0t: %s v0 read %h, expected %h", $time, name, v0_data, exp_v0);
        errors++;
      end
      if (check_word) begin
        assert (rd_data[0][31:0] === exp_word) else begin
          $display("FAIL %0t: %s port 0 low word %h, case file expects %h",
                   $time, name, rd_data[0][31:0], exp_word);
          errors++;
        end
      end
    end
    // Single request, so valid drops after one cycle
    @(negedge clk);
    assert (rd_valid === 1'b0) else begin
      $display("FAIL %0t: %s rd_valid high for more than one cycle", $time, name);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - err_before);
      failed_tests++;
    end
  endtask

  task automatic reset_test();
    int err_before;
    err_before = errors;
    repeat (2) begin
      @(negedge clk);
      assert (rd_valid === 1'b0) else begin
        $display("FAIL %0t: reset read rd_valid high with no request", $time);
        errors++;
      end
    end
    raddr[0] = 5'd0;
    raddr[1] = 5'd7;
    raddr[2] = 5'd19;
    raddr[3] = 5'd31;
    capture_expected();
    @(posedge clk);
    issue_read();
    @(posedge clk);
    rd_req <= 1'b0;
    collect_read("reset read", 1'b1, 32'h0);
    report_test("reset read", err_before);
  endtask

  task automatic run_case(input int k);
    int          mode;
    int          err_before;
    logic [31:0] exp_word;
    string       name;
    err_before = errors;
    name       = $sformatf("case %0d", k);
    load_case(k, mode, exp_word);
    // Mode 3 reads at the edge of the VRF write and sees the old contents
    if (mode == 3) begin
      capture_expected();
    end
    apply_model();
    if (mode != 3) begin
      capture_expected();
    end
    @(posedge clk);
    drive_lanes();
    @(posedge clk);
    drive_no_write();
    if (mode != 3) begin
      @(posedge clk);
    end
    issue_read();
    @(posedge clk);
    rd_req <= 1'b0;
    collect_read(name, (mode == 1) || (mode == 3), exp_word);
    report_test(name, err_before);
  endtask

  initial begin
    seed         = 32'ha0c98288;
    errors       = 0;
    failed_tests = 0;
    rst_n        = 1'b0;
    rd_req       = 1'b0;
    for (int p = 0; p < `WB_PORTS; p++) begin
      wb_op[p]     = rvv_wb_pkg::WB_NONE;
      wb_index[p]  = '0;
      wb_data[p]   = '0;
      wb_strobe[p] = '0;
    end
    for (int p = 0; p < `RD_PORTS; p++) begin
      rd_addr[p] = '0;
    end
    for (int r = 0; r < `VREG_NUM; r++) begin
      model[r] = '0;
    end
    $readmemh("testbench/vrf_cases.txt", case_mem);
    if (!$isunknown(case_mem[NUM_CASES*CASE_WORDS-1])) begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      reset_test();
      for (int k = 0; k < NUM_CASES; k++) begin
        run_case(k);
      end
    end else begin
      $display("Case file could not be read or holds fewer than %0d cases", NUM_CASES);
      errors++;
    end
    $display("%0d tests run, %0d failed, %0d check errors", NUM_CASES + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/rvv_backend_vrf_top.sv */
// Top level of the vector register file subsystem: retire, VRF and dispatch reader
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_vrf_top (
  input  logic                clk,
  input  logic                rst_n,
  input  rvv_wb_pkg::wb_op_e  wb_op     [`WB_PORTS],
  input  rvv_vrf_pkg::vidx_t  wb_index  [`WB_PORTS],
  input  rvv_vrf_pkg::vreg_t  wb_data   [`WB_PORTS],
  input  rvv_vrf_pkg::vstrb_t wb_strobe [`WB_PORTS],
  input  logic                rd_req,
  input  rvv_vrf_pkg::vidx_t  rd_addr   [`RD_PORTS],
  output logic                rd_valid,
  output rvv_vrf_pkg::vreg_t  rd_data   [`RD_PORTS],
  output rvv_vrf_pkg::vreg_t  v0_data
);

  rt2vrf_if i_rt2vrf ();
  dp2vrf_if i_dp2vrf ();

  // Write path
  rvv_backend_retire i_retire (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_op     (wb_op),
    .wb_index  (wb_index),
    .wb_data   (wb_data),
    .wb_strobe (wb_strobe),
    .rt2vrf    (i_rt2vrf.retire)
  );

  rvv_backend_vrf i_vrf (
    .clk    (clk),
    .rst_n  (rst_n),
    .rt2vrf (i_rt2vrf.vrf),
    .dp2vrf (i_dp2vrf.vrf)
  );

  // Read path
  rvv_backend_dispatch_read i_dispatch_read (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .v0_data  (v0_data),
    .dp2vrf   (i_dp2vrf.dispatch)
  );

endmodule

/* verilog/rvv_backend_dispatch_read.sv */
// Dispatch operand reader: read addresses out, registered operands and v0 back
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_dispatch_read (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd_req,
  input  rvv_vrf_pkg::vidx_t rd_addr [`RD_PORTS],
  output logic               rd_valid,
  output rvv_vrf_pkg::vreg_t rd_data [`RD_PORTS],
  output rvv_vrf_pkg::vreg_t v0_data,
  dp2vrf_if.dispatch         dp2vrf
);

  assign dp2vrf.rd_addr0 = rd_addr[0];
  assign dp2vrf.rd_addr1 = rd_addr[1];
  assign dp2vrf.rd_addr2 = rd_addr[2];
  assign dp2vrf.rd_addr3 = rd_addr[3];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req;
    end
  end

  // Operands hold until the next request
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_data[0] <= dp2vrf.rd_data0;
      rd_data[1] <= dp2vrf.rd_data1;
      rd_data[2] <= dp2vrf.rd_data2;
      rd_data[3] <= dp2vrf.rd_data3;
      v0_data    <= dp2vrf.v0_data;
    end
  end

  // One-cycle read latency, no stalls
  a_valid_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid == $past(rd_req));

endmodule

/* verilog/rvv_backend_vrf.sv */
// Vector register file: strobed write merge, register core, operand read muxes
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_vrf (
  input  logic     clk,
  input  logic     rst_n,
  rt2vrf_if.vrf    rt2vrf,
  dp2vrf_if.vrf    dp2vrf
);

  rvv_vrf_pkg::vreg_t [`VREG_NUM-1:0] vreg;
  rvv_vrf_pkg::vreg_t [`VREG_NUM-1:0] vrf_wdata;
  logic [`VREG_NUM-1:0]               vrf_wen;
  rvv_vrf_pkg::vreg_t [`WB_PORTS-1:0] wr_mask;
  rvv_vrf_pkg::vreg_t [`WB_PORTS-1:0] wr_merged;

  function automatic rvv_vrf_pkg::vreg_t strb_to_mask(input rvv_vrf_pkg::vstrb_t strb);
    rvv_vrf_pkg::vreg_t mask;
    for (int b = 0; b < `VLENB; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  // New bytes where strobed, old register contents elsewhere
  always_comb begin
    for (int l = 0; l < `WB_PORTS; l++) begin
      wr_mask[l]   = strb_to_mask(rt2vrf.wr_lane[l].rt_strobe);
      wr_merged[l] = (rt2vrf.wr_lane[l].rt_data & wr_mask[l]) |
                     (vreg[rt2vrf.wr_lane[l].rt_index] & ~wr_mask[l]);
    end
  end

  // Lanes hit distinct registers, OR is enough
  always_comb begin
    vrf_wen   = '0;
    vrf_wdata = '0;
    for (int l = 0; l < `WB_PORTS; l++) begin
      if (rt2vrf.wr_valid[l]) begin
        vrf_wen[rt2vrf.wr_lane[l].rt_index]   = 1'b1;
        vrf_wdata[rt2vrf.wr_lane[l].rt_index] = vrf_wdata[rt2vrf.wr_lane[l].rt_index] |
                                                wr_merged[l];
      end
    end
  end

  rvv_backend_vrf_reg i_vrf_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .wen   (vrf_wen),
    .wdata (vrf_wdata),
    .vreg  (vreg)
  );

  assign dp2vrf.rd_data0 = vreg[dp2vrf.rd_addr0];
  assign dp2vrf.rd_data1 = vreg[dp2vrf.rd_addr1];
  assign dp2vrf.rd_data2 = vreg[dp2vrf.rd_addr2];
  assign dp2vrf.rd_data3 = vreg[dp2vrf.rd_addr3];
  assign dp2vrf.v0_data  = vreg[0];

  // One enabled register per valid lane, never more than four
  a_wen_count: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(vrf_wen) == $countones(rt2vrf.wr_valid));

endmodule

/* verilog/rvv_backend_retire.sv */
// Retire write-back stage: opcode to strobe, lane collision merge, lane registers
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_retire (
  input  logic                clk,
  input  logic                rst_n,
  input  rvv_wb_pkg::wb_op_e  wb_op     [`WB_PORTS],
  input  rvv_vrf_pkg::vidx_t  wb_index  [`WB_PORTS],
  input  rvv_vrf_pkg::vreg_t  wb_data   [`WB_PORTS],
  input  rvv_vrf_pkg::vstrb_t wb_strobe [`WB_PORTS],
  rt2vrf_if.retire            rt2vrf
);

  rvv_vrf_pkg::vstrb_t                      lane_strb [`WB_PORTS];
  logic [`WB_PORTS-1:0]                     lane_act;
  logic [`WB_PORTS-1:0]                     lane_keep;
  rvv_wb_pkg::rt2vrf_lane_t [`WB_PORTS-1:0] lane_res;
  logic [`WB_PORTS-1:0]                     valid_q;
  rvv_wb_pkg::rt2vrf_lane_t [`WB_PORTS-1:0] lane_q;

  // Opcode to byte strobe
  always_comb begin
    for (int l = 0; l < `WB_PORTS; l++) begin
      case (wb_op[l])
        rvv_wb_pkg::WB_FULL:   lane_strb[l] = '1;
        rvv_wb_pkg::WB_MASKED: lane_strb[l] = wb_strobe[l];
        default:               lane_strb[l] = '0;
      endcase
      lane_act[l] = (wb_op[l] != rvv_wb_pkg::WB_NONE);
    end
  end

  // Highest active lane on an index survives and collects lower lanes' bytes
  always_comb begin
    for (int l = 0; l < `WB_PORTS; l++) begin
      lane_keep[l] = lane_act[l];
      for (int h = l + 1; h < `WB_PORTS; h++) begin
        if (lane_act[h] && (wb_index[h] == wb_index[l])) begin
          lane_keep[l] = 1'b0;
        end
      end
      lane_res[l].rt_index  = wb_index[l];
      lane_res[l].rt_data   = '0;
      lane_res[l].rt_strobe = '0;
      // Ascending order so the later lane's byte wins
      for (int k = 0; k <= l; k++) begin
        if (lane_act[k] && (wb_index[k] == wb_index[l])) begin
          lane_res[l].rt_strobe = lane_res[l].rt_strobe | lane_strb[k];
          for (int b = 0; b < `VLENB; b++) begin
            if (lane_strb[k][b]) begin
              lane_res[l].rt_data[b*8 +: 8] = wb_data[k][b*8 +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= lane_keep;
    end
  end

  always_ff @(posedge clk) begin
    lane_q <= lane_res;
  end

  assign rt2vrf.wr_valid = valid_q;
  assign rt2vrf.wr_lane  = lane_q;

  // VRF ORs lanes together, so indices must be unique
  for (genvar i = 0; i < `WB_PORTS; i++) begin : g_uniq_i
    for (genvar j = i + 1; j < `WB_PORTS; j++) begin : g_uniq_j
      a_unique_index: assert property (@(posedge clk) disable iff (!rst_n)
        !(valid_q[i] && valid_q[j] && (lane_q[i].rt_index == lane_q[j].rt_index)));
    end
  end

endmodule

/* verilog/rvv_backend_vrf_reg.sv */
// Storage array of the vector registers with per-register write enable
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_vrf_reg (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [`VREG_NUM-1:0]               wen,
  input  rvv_vrf_pkg::vreg_t [`VREG_NUM-1:0] wdata,
  output rvv_vrf_pkg::vreg_t [`VREG_NUM-1:0] vreg
);

  // Registers come out of reset as zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vreg <= '0;
    end else begin
      for (int r = 0; r < `VREG_NUM; r++) begin
        if (wen[r]) begin
          vreg[r] <= wdata[r];
        end
      end
    end
  end

endmodule

/* verilog/rvv_backend_if.sv */
// Retire-to-VRF write interface and dispatch-to-VRF read interface
`timescale 1ns/1ps
`include "rvv_config.svh"

// Write lanes from retire, applied at the next edge
interface rt2vrf_if;

  logic [`WB_PORTS-1:0]                     wr_valid;
  rvv_wb_pkg::rt2vrf_lane_t [`WB_PORTS-1:0] wr_lane;

  modport retire (
    output wr_valid,
    output wr_lane
  );

  modport vrf (
    input wr_valid,
    input wr_lane
  );

endinterface

// Operand reads, combinational from current state
interface dp2vrf_if;

  rvv_vrf_pkg::vidx_t rd_addr0;
  rvv_vrf_pkg::vidx_t rd_addr1;
  rvv_vrf_pkg::vidx_t rd_addr2;
  rvv_vrf_pkg::vidx_t rd_addr3;
  rvv_vrf_pkg::vreg_t rd_data0;
  rvv_vrf_pkg::vreg_t rd_data1;
  rvv_vrf_pkg::vreg_t rd_data2;
  rvv_vrf_pkg::vreg_t rd_data3;
  rvv_vrf_pkg::vreg_t v0_data;

  modport dispatch (
    output rd_addr0, rd_addr1, rd_addr2, rd_addr3,
    input  rd_data0, rd_data1, rd_data2, rd_data3,
    input  v0_data
  );

  modport vrf (
    input  rd_addr0, rd_addr1, rd_addr2, rd_addr3,
    output rd_data0, rd_data1, rd_data2, rd_data3,
    output v0_data
  );

endinterface

/* verilog/rvv_wb_pkg.sv */
// Write-back types: lane opcode and resolved write lane
`include "rvv_config.svh"

package rvv_wb_pkg;

  // WB_NONE idles the lane, WB_FULL ignores the strobe
  typedef enum logic [1:0] {
    WB_NONE   = 2'b00,
    WB_FULL   = 2'b01,
    WB_MASKED = 2'b10
  } wb_op_e;

  // Lane as seen by the VRF, strobe already expanded
  typedef struct packed {
    rvv_vrf_pkg::vidx_t  rt_index;
    rvv_vrf_pkg::vreg_t  rt_data;
    rvv_vrf_pkg::vstrb_t rt_strobe;
  } rt2vrf_lane_t;

endpackage

/* verilog/rvv_vrf_pkg.sv */
// Storage types: register data, byte strobe and register index
`include "rvv_config.svh"

package rvv_vrf_pkg;

  // One vector register
  typedef logic [`VLEN-1:0] vreg_t;

  // One strobe bit per byte of a register
  typedef logic [`VLENB-1:0] vstrb_t;

  // Register index
  typedef logic [`REGFILE_INDEX_WIDTH-1:0] vidx_t;

endpackage

/* verilog/rvv_config.svh */
// Sizing macros for the vector register file
`ifndef RVV_CONFIG_SVH
`define RVV_CONFIG_SVH

// Register width and bytes per register
`define VLEN 128
`define VLENB (`VLEN / 8)

// Register count and index width
`define VREG_NUM 32
`define REGFILE_INDEX_WIDTH 5

// Write-back lanes and operand read ports
`define WB_PORTS 4
`define RD_PORTS 4

`endif
